// ==== aluCore_settings.svh ====
`ifndef ALUCORE_SETTINGS_SVH
`define ALUCORE_SETTINGS_SVH

// Operand and result width.
`define DATA_WIDTH 16

// Register file size and index width.
`define REG_COUNT 8
`define REG_INDEX_WIDTH 3

// Only the low bits of operand B count for a shift.
`define SHIFT_WIDTH 4

`endif

// ==== aluPkg.sv ====
package aluPkg;

   // ================================================
   // ALU operation codes.
   // ================================================
   localparam logic [3:0] aluOpAdd = 4'b0000;
   localparam logic [3:0] aluOpSub = 4'b0001;
   localparam logic [3:0] aluOpAnd = 4'b0010;
   localparam logic [3:0] aluOpOr  = 4'b0011;
   localparam logic [3:0] aluOpXor = 4'b0100;
   localparam logic [3:0] aluOpSll = 4'b1000;
   localparam logic [3:0] aluOpSlr = 4'b1001;
   localparam logic [3:0] aluOpSrl = 4'b1010;
   localparam logic [3:0] aluOpSra = 4'b1011;
   localparam logic [3:0] aluOpIdt = 4'b1100;
   localparam logic [3:0] aluOpNon = 4'b1111;

   // ================================================
   // Bit positions in the flag word in S Z C V order.
   // ================================================
   localparam int flagSign     = 3;
   localparam int flagZero     = 2;
   localparam int flagCarry    = 1;
   localparam int flagOverflow = 0;

endpackage

// ==== instrPkg.sv ====
`include "aluCore_settings.svh"

package instrPkg;

   // One 16-bit word, read as register form or immediate form.
   typedef union packed {
      struct packed {
         logic [1:0]                  op1;
         logic [`REG_INDEX_WIDTH-1:0] rs;
         logic [`REG_INDEX_WIDTH-1:0] rd;
         logic [3:0]                  op3;
         logic [3:0]                  d;
      } regForm;
      struct packed {
         logic [1:0]                  op1;
         logic [2:0]                  op2;
         logic [`REG_INDEX_WIDTH-1:0] rb;
         logic [7:0]                  imm;
      } immForm;
   } instrWord;

   // Format selectors.
   localparam logic [1:0] op1Reg = 2'b11;
   localparam logic [1:0] op1Imm = 2'b10;

   // Register form operations.
   localparam logic [3:0] op3Add = 4'd0;
   localparam logic [3:0] op3Sub = 4'd1;
   localparam logic [3:0] op3And = 4'd2;
   localparam logic [3:0] op3Or  = 4'd3;
   localparam logic [3:0] op3Xor = 4'd4;
   localparam logic [3:0] op3Cmp = 4'd5;
   localparam logic [3:0] op3Mov = 4'd6;
   localparam logic [3:0] op3Sll = 4'd8;
   localparam logic [3:0] op3Slr = 4'd9;
   localparam logic [3:0] op3Srl = 4'd10;
   localparam logic [3:0] op3Sra = 4'd11;
   localparam logic [3:0] op3Out = 4'd13;

   // Immediate form operations.
   localparam logic [2:0] op2Li   = 3'd0;
   localparam logic [2:0] op2Addi = 3'd1;
   localparam logic [2:0] op2Cmpi = 3'd2;

endpackage

// ==== regFile.sv ====
`include "aluCore_settings.svh"

module regFile (
   input  logic                        clock,
   input  logic                        reset,
   input  logic [`REG_INDEX_WIDTH-1:0] readRegA,
   input  logic [`REG_INDEX_WIDTH-1:0] readRegB,
   output logic [`DATA_WIDTH-1:0]      readDataA,
   output logic [`DATA_WIDTH-1:0]      readDataB,
   input  logic                        writeEnable,
   input  logic [`REG_INDEX_WIDTH-1:0] writeReg,
   input  logic [`DATA_WIDTH-1:0]      writeData
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   // Both read ports are asynchronous.
   assign readDataA = regs[readRegA];
   assign readDataB = regs[readRegB];

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEnable) begin
         regs[writeReg] <= writeData;
      end
   end

endmodule

// ==== alu.sv ====
`include "aluCore_settings.svh"

module alu (
   input  logic [`DATA_WIDTH-1:0] dataA,
   input  logic [`DATA_WIDTH-1:0] dataB,
   input  logic [3:0]             aluOp,
   output logic [`DATA_WIDTH-1:0] aluResult,
   output logic [3:0]             aluFlags
);
   import aluPkg::*;

   logic [`SHIFT_WIDTH-1:0] shamt;
   logic [`DATA_WIDTH:0]    shiftLeft;
   logic                    rightCarry;
   logic [`DATA_WIDTH:0]    wideResult;
   logic                    overflow;

   assign shamt     = dataB[`SHIFT_WIDTH-1:0];
   assign shiftLeft = {1'b0, dataA} << shamt;

   // Last bit shifted out on the right.
   assign rightCarry = (shamt != '0) ? dataA[shamt - 1'b1] : 1'b0;

   // ================================================
   // Operation select with bit 16 as the carry.
   // ================================================
   always_comb begin
      case (aluOp)
         aluOpAdd: wideResult = {1'b0, dataA} + {1'b0, dataB};
         aluOpSub: wideResult = {1'b0, dataA} - {1'b0, dataB};
         aluOpAnd: wideResult = {1'b0, dataA & dataB};
         aluOpOr:  wideResult = {1'b0, dataA | dataB};
         aluOpXor: wideResult = {1'b0, dataA ^ dataB};
         aluOpSll: wideResult = shiftLeft;
         aluOpSlr: begin
            // Rotate left; bits leaving the top come back in at the bottom.
            wideResult = {shiftLeft[`DATA_WIDTH],
                          shiftLeft[`DATA_WIDTH-1:0] | (dataA >> (`DATA_WIDTH - shamt))};
         end
         aluOpSrl: wideResult = {rightCarry, dataA >> shamt};
         aluOpSra: wideResult = {rightCarry, $signed(dataA) >>> shamt};
         aluOpIdt: wideResult = {1'b0, dataA};
         aluOpNon: wideResult = '0;
         default:  wideResult = '0;
      endcase
   end

   // Signed overflow only exists for add and subtract.
   assign overflow =
      ((aluOp == aluOpAdd) && (dataA[`DATA_WIDTH-1] == dataB[`DATA_WIDTH-1])
         && (dataA[`DATA_WIDTH-1] != wideResult[`DATA_WIDTH-1]))
      || ((aluOp == aluOpSub) && (dataA[`DATA_WIDTH-1] != dataB[`DATA_WIDTH-1])
         && (dataA[`DATA_WIDTH-1] != wideResult[`DATA_WIDTH-1]));

   // ================================================
   // Flag word.
   // ================================================
   always_comb begin
      aluFlags               = '0;
      aluFlags[flagSign]     = wideResult[`DATA_WIDTH-1];
      aluFlags[flagZero]     = (wideResult[`DATA_WIDTH-1:0] == '0);
      aluFlags[flagCarry]    = wideResult[`DATA_WIDTH];
      aluFlags[flagOverflow] = overflow;
   end

   assign aluResult = wideResult[`DATA_WIDTH-1:0];

endmodule

// ==== instrDecode.sv ====
`include "aluCore_settings.svh"

module instrDecode (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        instrValid,
   input  instrPkg::instrWord          instr,
   output logic [`REG_INDEX_WIDTH-1:0] readRegA,
   output logic [`REG_INDEX_WIDTH-1:0] readRegB,
   input  logic [`DATA_WIDTH-1:0]      readDataA,
   input  logic [`DATA_WIDTH-1:0]      readDataB,
   input  logic [`DATA_WIDTH-1:0]      aluResult,
   output logic [`DATA_WIDTH-1:0]      operandA,
   output logic [`DATA_WIDTH-1:0]      operandB,
   output logic [3:0]                  aluOp,
   output logic                        issueValid,
   output logic                        writeEnable,
   output logic                        flagEnable,
   output logic                        outEnable,
   output logic [`REG_INDEX_WIDTH-1:0] destReg
);
   import instrPkg::*;
   import aluPkg::*;

   logic                        isRegForm;
   logic                        isImmForm;
   logic                        forwardA;
   logic                        forwardB;
   logic [`DATA_WIDTH-1:0]      sourceA;
   logic [`DATA_WIDTH-1:0]      sourceB;
   logic [`DATA_WIDTH-1:0]      immValue;
   logic [`DATA_WIDTH-1:0]      shiftValue;
   logic                        decLegal;
   logic                        decWrite;
   logic                        decFlag;
   logic                        decOut;
   logic [3:0]                  decAluOp;
   logic [`DATA_WIDTH-1:0]      decOperandA;
   logic [`DATA_WIDTH-1:0]      decOperandB;
   logic [`REG_INDEX_WIDTH-1:0] decDest;

   assign isRegForm = (instr.regForm.op1 == op1Reg);
   assign isImmForm = (instr.immForm.op1 == op1Imm);

   // Rd and Rb share the same bits, so port A reads the destination in both forms.
   assign readRegA = instr.regForm.rd;
   assign readRegB = instr.regForm.rs;

   // ================================================
   // Forwarding from the instruction in flight.
   // ================================================
   assign forwardA = issueValid && writeEnable && (destReg == readRegA);
   assign forwardB = issueValid && writeEnable && (destReg == readRegB);
   assign sourceA  = forwardA ? aluResult : readDataA;
   assign sourceB  = forwardB ? aluResult : readDataB;

   assign immValue   = {{(`DATA_WIDTH-8){instr.immForm.imm[7]}}, instr.immForm.imm};
   assign shiftValue = {{(`DATA_WIDTH-`SHIFT_WIDTH){1'b0}}, instr.regForm.d};

   // ================================================
   // Instruction decode.
   // ================================================
   always_comb begin
      decLegal    = 1'b0;
      decWrite    = 1'b0;
      decFlag     = 1'b0;
      decOut      = 1'b0;
      decAluOp    = aluOpNon;
      decOperandA = sourceA;
      decOperandB = sourceB;
      decDest     = instr.regForm.rd;
      if (isRegForm) begin
         // Every ALU operation updates the flags unless cleared below.
         decLegal = 1'b1;
         decWrite = 1'b1;
         decFlag  = 1'b1;
         case (instr.regForm.op3)
            op3Add: decAluOp = aluOpAdd;
            op3Sub: decAluOp = aluOpSub;
            op3And: decAluOp = aluOpAnd;
            op3Or:  decAluOp = aluOpOr;
            op3Xor: decAluOp = aluOpXor;
            op3Cmp: begin
               decAluOp = aluOpSub;
               decWrite = 1'b0;
            end
            op3Mov: begin
               decAluOp    = aluOpIdt;
               decOperandA = sourceB;
            end
            op3Sll: begin
               decAluOp    = aluOpSll;
               decOperandB = shiftValue;
            end
            op3Slr: begin
               decAluOp    = aluOpSlr;
               decOperandB = shiftValue;
            end
            op3Srl: begin
               decAluOp    = aluOpSrl;
               decOperandB = shiftValue;
            end
            op3Sra: begin
               decAluOp    = aluOpSra;
               decOperandB = shiftValue;
            end
            op3Out: begin
               decAluOp    = aluOpIdt;
               decOperandA = sourceB;
               decWrite    = 1'b0;
               decFlag     = 1'b0;
               decOut      = 1'b1;
            end
            default: begin
               decLegal = 1'b0;
               decWrite = 1'b0;
               decFlag  = 1'b0;
            end
         endcase
      end else if (isImmForm) begin
         decLegal    = 1'b1;
         decWrite    = 1'b1;
         decFlag     = 1'b1;
         decOperandB = immValue;
         case (instr.immForm.op2)
            op2Li: begin
               decAluOp    = aluOpIdt;
               decOperandA = immValue;
            end
            op2Addi: decAluOp = aluOpAdd;
            op2Cmpi: begin
               decAluOp = aluOpSub;
               decWrite = 1'b0;
            end
            default: begin
               decLegal = 1'b0;
               decWrite = 1'b0;
               decFlag  = 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         issueValid  <= 1'b0;
         writeEnable <= 1'b0;
         flagEnable  <= 1'b0;
         outEnable   <= 1'b0;
         aluOp       <= aluOpNon;
      end else begin
         issueValid  <= instrValid && decLegal;
         writeEnable <= instrValid && decWrite;
         flagEnable  <= instrValid && decFlag;
         outEnable   <= instrValid && decOut;
         aluOp       <= decAluOp;
      end
   end

   always_ff @(posedge clock) begin
      if (instrValid) begin
         operandA <= decOperandA;
         operandB <= decOperandB;
         destReg  <= decDest;
      end
   end

endmodule

// ==== resultStage.sv ====
`include "aluCore_settings.svh"

module resultStage (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        issueValid,
   input  logic                        writeEnable,
   input  logic                        flagEnable,
   input  logic                        outEnable,
   input  logic [`REG_INDEX_WIDTH-1:0] destReg,
   input  logic [`DATA_WIDTH-1:0]      aluResult,
   input  logic [3:0]                  aluFlags,
   output logic                        wbEnable,
   output logic [`REG_INDEX_WIDTH-1:0] wbReg,
   output logic [`DATA_WIDTH-1:0]      wbData,
   output logic                        resultValid,
   output logic [`DATA_WIDTH-1:0]      result,
   output logic [3:0]                  flags,
   output logic                        outStrobe,
   output logic [`DATA_WIDTH-1:0]      outData
);

   logic aluDone;
   logic outDone;

   assign aluDone = issueValid && !outEnable;
   assign outDone = issueValid && outEnable;

   // Write-back lands on the same edge that registers the result.
   assign wbEnable = issueValid && writeEnable;
   assign wbReg    = destReg;
   assign wbData   = aluResult;

   always_ff @(posedge clock) begin
      if (reset) begin
         resultValid <= 1'b0;
         result      <= '0;
         flags       <= '0;
         outStrobe   <= 1'b0;
         outData     <= '0;
      end else begin
         resultValid <= aluDone;
         outStrobe   <= outDone;
         if (aluDone) begin
            result <= aluResult;
         end
         if (issueValid && flagEnable) begin
            flags <= aluFlags;
         end
         // OUT carries Rs through the ALU unchanged.
         if (outDone) begin
            outData <= aluResult;
         end
      end
   end

endmodule

// ==== execCore.sv ====
`include "aluCore_settings.svh"

module execCore (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   instrValid,
   input  instrPkg::instrWord     instr,
   output logic                   resultValid,
   output logic [`DATA_WIDTH-1:0] result,
   output logic [3:0]             flags,
   output logic                   outStrobe,
   output logic [`DATA_WIDTH-1:0] outData
);

   logic [`REG_INDEX_WIDTH-1:0] readRegA;
   logic [`REG_INDEX_WIDTH-1:0] readRegB;
   logic [`DATA_WIDTH-1:0]      readDataA;
   logic [`DATA_WIDTH-1:0]      readDataB;
   logic [`DATA_WIDTH-1:0]      operandA;
   logic [`DATA_WIDTH-1:0]      operandB;
   logic [3:0]                  aluOp;
   logic [`DATA_WIDTH-1:0]      aluResult;
   logic [3:0]                  aluFlags;
   logic                        issueValid;
   logic                        writeEnable;
   logic                        flagEnable;
   logic                        outEnable;
   logic [`REG_INDEX_WIDTH-1:0] destReg;
   logic                        wbEnable;
   logic [`REG_INDEX_WIDTH-1:0] wbReg;
   logic [`DATA_WIDTH-1:0]      wbData;

   // ================================================
   // Decode, operand read and forwarding.
   // ================================================
   instrDecode instrDecode_i (
      .clock       (clock),
      .reset       (reset),
      .instrValid  (instrValid),
      .instr       (instr),
      .readRegA    (readRegA),
      .readRegB    (readRegB),
      .readDataA   (readDataA),
      .readDataB   (readDataB),
      .aluResult   (aluResult),
      .operandA    (operandA),
      .operandB    (operandB),
      .aluOp       (aluOp),
      .issueValid  (issueValid),
      .writeEnable (writeEnable),
      .flagEnable  (flagEnable),
      .outEnable   (outEnable),
      .destReg     (destReg)
   );

   regFile regFile_i (
      .clock       (clock),
      .reset       (reset),
      .readRegA    (readRegA),
      .readRegB    (readRegB),
      .readDataA   (readDataA),
      .readDataB   (readDataB),
      .writeEnable (wbEnable),
      .writeReg    (wbReg),
      .writeData   (wbData)
   );

   alu alu_i (
      .dataA     (operandA),
      .dataB     (operandB),
      .aluOp     (aluOp),
      .aluResult (aluResult),
      .aluFlags  (aluFlags)
   );

   // ================================================
   // Result, write-back and output port.
   // ================================================
   resultStage resultStage_i (
      .clock       (clock),
      .reset       (reset),
      .issueValid  (issueValid),
      .writeEnable (writeEnable),
      .flagEnable  (flagEnable),
      .outEnable   (outEnable),
      .destReg     (destReg),
      .aluResult   (aluResult),
      .aluFlags    (aluFlags),
      .wbEnable    (wbEnable),
      .wbReg       (wbReg),
      .wbData      (wbData),
      .resultValid (resultValid),
      .result      (result),
      .flags       (flags),
      .outStrobe   (outStrobe),
      .outData     (outData)
   );

endmodule

// ==== execCore_tb.sv ====
`include "aluCore_settings.svh"

module execCore_tb;
   import instrPkg::*;

   localparam int clockPeriod   = 100;
   localparam int resetCycles   = 16;
   localparam int randomCount   = 120;
   localparam int compareRounds = 12;
   localparam int chainCount    = 80;
   localparam int noopCount     = 40;

   // Worst case slot count over all sections with gaps and OUT sweeps.
   localparam int instrBudget = 40 + 2 * randomCount + 256 + 6 * compareRounds
                                + 2 * chainCount + 2 * noopCount + 16;
   localparam int watchdogCycles = resetCycles + instrBudget + 40;

   logic                   clock;
   logic                   reset;
   logic                   instrValid;
   instrWord               instr;
   logic                   resultValid;
   logic [`DATA_WIDTH-1:0] result;
   logic [3:0]             flags;
   logic                   outStrobe;
   logic [`DATA_WIDTH-1:0] outData;

   // Shadow state of the reference model.
   logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
   logic [3:0]             shadowFlags;
   logic [31:0]            rngState;
   int                     cycleCount = 0;
   int                     mismatchCount = 0;
   int                     strobeErrors = 0;

   // Expected completions in issue order.
   bit                     expIsOut [$];
   logic [`DATA_WIDTH-1:0] expValue [$];
   logic [3:0]             expFlags [$];
   int                     expDue [$];

   bit                     checkIsOut;
   logic [`DATA_WIDTH-1:0] checkValue;
   logic [3:0]             checkFlags;

   execCore execCore_i (
      .clock       (clock),
      .reset       (reset),
      .instrValid  (instrValid),
      .instr       (instr),
      .resultValid (resultValid),
      .result      (result),
      .flags       (flags),
      .outStrobe   (outStrobe),
      .outData     (outData)
   );

   initial clock = 1'b0;
   always #(clockPeriod / 2) clock = ~clock;

   always @(posedge clock) begin
      cycleCount <= cycleCount + 1;
   end

   // ================================================
   // Reference model.
   // ================================================
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift(rngState);
      return rngState;
   endfunction

   // Op codes follow op3; MOV stands for a plain pass of A.
   function automatic logic [15:0] aluReference(input logic [3:0] op, input logic [15:0] a,
                                                input logic [15:0] b,
                                                output logic [3:0] newFlags);
      logic [16:0] wide;
      logic [15:0] bits;
      logic        carry;
      logic        overflow;
      int          signedValue;
      bits     = a;
      carry    = 1'b0;
      overflow = 1'b0;
      case (op)
         op3Add: begin
            wide        = {1'b0, a} + {1'b0, b};
            signedValue = int'($signed(a)) + int'($signed(b));
            overflow    = (signedValue > 32767) || (signedValue < -32768);
         end
         op3Sub, op3Cmp: begin
            wide        = {1'b0, a} - {1'b0, b};
            signedValue = int'($signed(a)) - int'($signed(b));
            overflow    = (signedValue > 32767) || (signedValue < -32768);
         end
         op3And: wide = {1'b0, a & b};
         op3Or:  wide = {1'b0, a | b};
         op3Xor: wide = {1'b0, a ^ b};
         op3Sll, op3Slr, op3Srl, op3Sra: begin
            // Shift one bit per step and keep the last bit that fell out as carry.
            for (int i = 0; i < int'(b[3:0]); i++) begin
               if (op == op3Sll || op == op3Slr) begin
                  carry = bits[15];
                  bits  = {bits[14:0], (op == op3Slr) ? bits[15] : 1'b0};
               end else begin
                  carry = bits[0];
                  bits  = {(op == op3Sra) ? bits[15] : 1'b0, bits[15:1]};
               end
            end
            wide = {carry, bits};
         end
         default: wide = {1'b0, a};
      endcase
      newFlags = {wide[15], (wide[15:0] == 16'h0000), wide[16], overflow};
      return wide[15:0];
   endfunction

   function automatic logic [15:0] regWord(input logic [3:0] op3, input logic [2:0] rs,
                                           input logic [2:0] rd, input logic [3:0] d);
      return {op1Reg, rs, rd, op3, d};
   endfunction

   function automatic logic [15:0] immWord(input logic [2:0] op2, input logic [2:0] rb,
                                           input logic [7:0] imm);
      return {op1Imm, op2, rb, imm};
   endfunction

   function automatic logic [3:0] unusedOp3(input logic [1:0] sel);
      case (sel)
         2'd0:    return 4'd7;
         2'd1:    return 4'd12;
         2'd2:    return 4'd14;
         default: return 4'd15;
      endcase
   endfunction

   task automatic queueExpected(input bit isOut, input logic [15:0] value,
                                input logic [3:0] newFlags);
      expIsOut.push_back(isOut);
      expValue.push_back(value);
      expFlags.push_back(newFlags);
      expDue.push_back(cycleCount + 2);
   endtask

   // Drives one valid word and steps the model in program order.
   task automatic issueWord(input logic [15:0] word);
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [3:0]  op;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] value;
      logic [3:0]  newFlags;
      logic        writes;
      logic        aluIssue;
      @(negedge clock);
      instrValid = 1'b1;
      instr      = word;
      rs       = word[13:11];
      rd       = word[10:8];
      op       = word[7:4];
      a        = shadowRegs[rd];
      b        = shadowRegs[rs];
      writes   = 1'b1;
      aluIssue = 1'b1;
      if (word[15:14] == op1Reg) begin
         case (word[7:4])
            op3Add, op3Sub, op3And, op3Or, op3Xor: writes = 1'b1;
            op3Cmp: writes = 1'b0;
            op3Mov: a = shadowRegs[rs];
            op3Sll, op3Slr, op3Srl, op3Sra: b = {12'h000, word[3:0]};
            op3Out: begin
               aluIssue = 1'b0;
               queueExpected(1'b1, shadowRegs[rs], shadowFlags);
            end
            default: aluIssue = 1'b0;
         endcase
      end else if (word[15:14] == op1Imm) begin
         b = {{8{word[7]}}, word[7:0]};
         case (word[13:11])
            op2Li: begin
               op = op3Mov;
               a  = b;
            end
            op2Addi: op = op3Add;
            op2Cmpi: begin
               op     = op3Cmp;
               writes = 1'b0;
            end
            default: aluIssue = 1'b0;
         endcase
      end else begin
         aluIssue = 1'b0;
      end
      if (aluIssue) begin
         value       = aluReference(op, a, b, newFlags);
         shadowFlags = newFlags;
         if (writes) begin
            shadowRegs[rd] = value;
         end
         queueExpected(1'b0, value, newFlags);
      end
   endtask

   task automatic idleCycle();
      @(negedge clock);
      instrValid = 1'b0;
      instr      = 16'(nextRandom());
   endtask

   task automatic outputAll();
      for (int i = 0; i < `REG_COUNT; i++) begin
         issueWord(regWord(op3Out, 3'(i), 3'd0, 4'd0));
      end
   endtask

   // ================================================
   // Checker on the falling edge.
   // ================================================
   always @(negedge clock) begin
      if (!reset) begin
         if (expDue.size() != 0 && expDue[0] == cycleCount) begin
            checkIsOut = expIsOut.pop_front();
            checkValue = expValue.pop_front();
            checkFlags = expFlags.pop_front();
            expDue.delete(0);
            if (!checkIsOut && (resultValid !== 1'b1 || outStrobe !== 1'b0)) begin
               $display("Error at time %0t: result strobe missing or output strobe raised",
                        $time);
               strobeErrors++;
            end
            if (checkIsOut && (outStrobe !== 1'b1 || resultValid !== 1'b0)) begin
               $display("Error at time %0t: output strobe missing or result strobe raised",
                        $time);
               strobeErrors++;
            end
            if (!checkIsOut && result !== checkValue) begin
               $display("Mismatch at time %0t: result expected %h got %h",
                        $time, checkValue, result);
               mismatchCount++;
            end
            if (checkIsOut && outData !== checkValue) begin
               $display("Mismatch at time %0t: outData expected %h got %h",
                        $time, checkValue, outData);
               mismatchCount++;
            end
            if (flags !== checkFlags) begin
               $display("Mismatch at time %0t: flags expected %b got %b",
                        $time, checkFlags, flags);
               mismatchCount++;
            end
         end else if (resultValid !== 1'b0 || outStrobe !== 1'b0) begin
            $display("Error at time %0t: strobe raised with no instruction due", $time);
            strobeErrors++;
         end
      end
   end

   initial begin
      #(watchdogCycles * clockPeriod);
      $display("Error: watchdog expired after %0d clock periods", watchdogCycles);
      $display("Errors: %0d mismatches, %0d strobe errors", mismatchCount, strobeErrors);
      $display("Something failed");
      $finish;
   end

   // ================================================
   // Stimulus.
   // ================================================
   initial begin
      logic [31:0] r;
      logic [15:0] word;
      logic [2:0]  prevDest;
      logic [2:0]  dest;
      reset       = 1'b1;
      instrValid  = 1'b0;
      instr       = '0;
      rngState    = 32'hb81bcfb6;
      shadowFlags = 4'h0;
      for (int i = 0; i < `REG_COUNT; i++) begin
         shadowRegs[3'(i)] = 16'h0000;
      end
      repeat (resetCycles) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      if (resultValid !== 1'b0 || outStrobe !== 1'b0 || result !== 16'h0000
          || outData !== 16'h0000 || flags !== 4'h0) begin
         $display("Mismatch at time %0t: outputs not cleared by reset", $time);
         mismatchCount++;
      end

      // Registers read zero before each one is loaded and read back.
      outputAll();
      for (int i = 0; i < `REG_COUNT; i++) begin
         r = nextRandom();
         issueWord(immWord(op2Li, 3'(i), r[7:0]));
      end
      outputAll();

      // Signed overflow on add and subtract.
      issueWord(immWord(op2Li, 3'd1, 8'h7f));
      issueWord(regWord(op3Sll, 3'd0, 3'd1, 4'd8));
      issueWord(regWord(op3Add, 3'd1, 3'd1, 4'd0));
      issueWord(immWord(op2Li, 3'd2, 8'h80));
      issueWord(regWord(op3Sll, 3'd0, 3'd2, 4'd8));
      issueWord(immWord(op2Li, 3'd3, 8'h01));
      issueWord(regWord(op3Sub, 3'd3, 3'd2, 4'd0));

      repeat (randomCount) begin
         r = nextRandom();
         if (r[31:29] == 3'd0) begin
            idleCycle();
         end
         case (r[2:0])
            3'd0:    word = regWord(op3Add, r[10:8], r[13:11], 4'd0);
            3'd1:    word = regWord(op3Sub, r[10:8], r[13:11], 4'd0);
            3'd2:    word = regWord(op3And, r[10:8], r[13:11], 4'd0);
            3'd3:    word = regWord(op3Or, r[10:8], r[13:11], 4'd0);
            3'd4:    word = regWord(op3Xor, r[10:8], r[13:11], 4'd0);
            3'd5:    word = regWord(op3Mov, r[10:8], r[13:11], 4'd0);
            3'd6:    word = immWord(op2Addi, r[13:11], r[23:16]);
            default: word = immWord(op2Li, r[13:11], r[23:16]);
         endcase
         issueWord(word);
      end

      // Every shift amount on a mixed 16-bit value.
      for (int op = 0; op < 4; op++) begin
         for (int d = 0; d < 16; d++) begin
            r = nextRandom();
            issueWord(immWord(op2Li, 3'd5, r[7:0]));
            issueWord(regWord(op3Sll, 3'd0, 3'd5, 4'd8));
            issueWord(immWord(op2Addi, 3'd5, r[15:8]));
            issueWord(regWord(op3Sll + 4'(op), 3'd0, 3'd5, 4'(d)));
         end
      end

      repeat (compareRounds) begin
         r = nextRandom();
         issueWord(immWord(op2Li, 3'd6, r[7:0]));
         issueWord(immWord(op2Li, 3'd7, r[15:8]));
         issueWord(regWord(op3Cmp, 3'd7, 3'd6, 4'd0));
         issueWord(regWord(op3Out, 3'd6, 3'd0, 4'd0));
         issueWord(immWord(op2Cmpi, 3'd7, r[23:16]));
         issueWord(regWord(op3Out, 3'd7, 3'd0, 4'd0));
      end

      // Each step reads the previous destination.
      prevDest = 3'd0;
      repeat (chainCount) begin
         r    = nextRandom();
         dest = r[10:8];
         case (r[2:0])
            3'd0: word = regWord(op3Add, prevDest, dest, 4'd0);
            3'd1: begin
               word = regWord(op3Sub, r[10:8], prevDest, 4'd0);
               dest = prevDest;
            end
            3'd2: word = regWord(op3Xor, prevDest, dest, 4'd0);
            3'd3: word = regWord(op3Mov, prevDest, dest, 4'd0);
            3'd4: begin
               word = immWord(op2Addi, prevDest, r[23:16]);
               dest = prevDest;
            end
            3'd5: begin
               word = regWord(op3Sll, 3'd0, prevDest, r[7:4]);
               dest = prevDest;
            end
            3'd6: begin
               word = regWord(op3Sra, 3'd0, prevDest, r[7:4]);
               dest = prevDest;
            end
            default: word = regWord(op3Or, prevDest, dest, 4'd0);
         endcase
         issueWord(word);
         if (r[31]) begin
            issueWord(regWord(op3Out, dest, 3'd0, 4'd0));
         end
         prevDest = dest;
      end

      repeat (noopCount) begin
         r = nextRandom();
         case (r[1:0])
            2'd0:    word = {1'b0, r[16:2]};
            2'd1:    word = regWord(unusedOp3(r[3:2]), r[6:4], r[9:7], r[13:10]);
            2'd2:    word = immWord(3'd3 + (r[6:4] % 3'd5), r[9:7], r[17:10]);
            default: word = {2'b01, r[15:2]};
         endcase
         issueWord(word);
         issueWord(regWord(op3Out, r[20:18], 3'd0, 4'd0));
      end
      outputAll();

      idleCycle();
      while (expDue.size() != 0) begin
         idleCycle();
      end
      // A few quiet cycles catch any late strobe.
      repeat (4) idleCycle();

      $display("Errors: %0d mismatches, %0d strobe errors", mismatchCount, strobeErrors);
      if (mismatchCount == 0 && strobeErrors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+.
aluPkg.sv
instrPkg.sv
regFile.sv
alu.sv
instrDecode.sv
resultStage.sv
execCore.sv
execCore_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the execCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing -Wno-fatal --top-module execCore_tb \
   -Mdir "$buildDir" -f build.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

"./$buildDir/VexecCore_tb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

# The testbench prints the pass line on its own.
if grep -qx "Everything OK" "$logFile"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation did not pass, see $logFile"
   exit 1
fi
